/* rgbwLamp.f */
+incdir+rtl
rtl/rgbwPkg.sv
rtl/cmdFrameParser.sv
rtl/hueEngine.sv
rtl/resultCollector.sv
rtl/rgbwLampTop.sv
test/clockGen.sv
test/rgbwLamp_assert.sv
test/rgbwLampTb.sv

/* Makefile */
# Verilator build and run of the RGBW lamp controller testbench

TOOL      = verilator
FLAGS     = --binary --timing --assert
TOP       = rgbwLampTb
FILELIST  = rgbwLamp.f
RUN_FLAGS = +verilator+error+limit+100
LOG       = sim.log
PASS_MSG  = *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* test/rgbwLampTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lamp controller testbench with record stimulus,
// color reference model, per-fixture scoreboard
// and the final report
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "rgbw_defs.svh"

module rgbwLampTb;

    localparam int TIMEOUT = 5000;

    logic                   clk;
    logic                   reset_sig;
    logic                   inValid;
    rgbwPkg::streamByteT    inByte;
    logic                   inReady;
    logic                   outValid;
    rgbwPkg::fixtureResultT outResult;
    logic                   outReady;

    // per-fixture queues of expected results
    rgbwPkg::rgbwT expQ [`NUM_FIXTURES][$];

    int errCount = 0;
    int timeoutCount = 0;
    int sentCount = 0;
    int gotCount = 0;
    int curFix = 0;
    bit gapsOn = 1'b0;
    bit stallOut = 1'b0;

    clockGen clocks (.clk(clk), .reset_sig(reset_sig));

    rgbwLampTop DUT (
        .clk       (clk),
        .reset_sig (reset_sig),
        .inValid   (inValid),
        .inByte    (inByte),
        .inReady   (inReady),
        .outValid  (outValid),
        .outResult (outResult),
        .outReady  (outReady)
    );

    function automatic int clip(input int v);
        return (v > 255) ? 255 : ((v < 0) ? 0 : v);
    endfunction

    // walk the wheel for steps 0..idx, then white add and shift
    function automatic rgbwPkg::rgbwT wheelResult(input logic [7:0] idx,
                                                  input logic [7:0] white,
                                                  input logic [7:0] intensity);
        int r;
        int g;
        int b;
        int sh;
        rgbwPkg::rgbwT res;
        r = 255;
        g = 0;
        b = 0;
        for (int s = 0; s <= int'(idx); s++) begin
            case (s / `SEG_LEN)
                0: b = clip(b + `WHEEL_STEP);
                1: r = clip(r - `WHEEL_STEP);
                2: g = clip(g + `WHEEL_STEP);
                3: b = clip(b - `WHEEL_STEP);
                4: r = clip(r + `WHEEL_STEP);
                5: g = clip(g - `WHEEL_STEP);
                default: ;
            endcase
        end
        r = clip(r + int'(white));
        g = clip(g + int'(white));
        b = clip(b + int'(white));
        sh = int'(intensity[7:5]);
        res.red   = 8'(r >> sh);
        res.green = 8'(g >> sh);
        res.blue  = 8'(b >> sh);
        res.white = white >> sh;
        return res;
    endfunction

    function automatic int pendingTotal();
        int total;
        total = 0;
        for (int f = 0; f < `NUM_FIXTURES; f++) begin
            total += expQ[f].size();
        end
        return total;
    endfunction

    task automatic finishRun();
        int assertFails;
        assertFails = DUT.protocolChecks.failCount;
        $display("errors: %0d value, %0d assertion, %0d timeout",
                 errCount, assertFails, timeoutCount);
        if (errCount == 0 && assertFails == 0 && timeoutCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    // later stimulus is skipped once a wait has timed out
    task automatic timedOut(input string what);
        $display("timeout: %s", what);
        timeoutCount++;
    endtask

    task automatic sendByte(input logic first, input logic [7:0] data);
        int waitCnt;
        int gap;
        if (timeoutCount > 0) return;
        if (gapsOn) begin
            gap = $urandom_range(0, 3);
            repeat (gap) begin
                inValid <= 1'b0;
                @(posedge clk);
            end
        end
        inValid <= 1'b1;
        inByte  <= {first, data};
        waitCnt = 0;
        do begin
            @(posedge clk);
            waitCnt++;
        end while (!inReady && waitCnt < TIMEOUT);
        if (!inReady) timedOut("inReady stayed low, input byte never taken");
    endtask

    task automatic putRecord(input logic [7:0] mode, input logic [7:0] intensity,
                             input logic [7:0] colorIdx, input logic [7:0] white,
                             input logic [7:0] red, input logic [7:0] green,
                             input logic [7:0] blue);
        logic first;
        first = (curFix == 0);
        if (mode == rgbwPkg::modeDirect) begin
            expQ[curFix].push_back({red, green, blue, white});
            sentCount++;
        end else if (mode == rgbwPkg::modeWheel) begin
            expQ[curFix].push_back(wheelResult(colorIdx, white, intensity));
            sentCount++;
        end
        sendByte(first, mode);
        sendByte(1'b0, intensity);
        sendByte(1'b0, colorIdx);
        sendByte(1'b0, white);
        sendByte(1'b0, red);
        sendByte(1'b0, green);
        sendByte(1'b0, blue);
        curFix = (curFix + 1) % `NUM_FIXTURES;
    endtask

    task automatic waitDrain();
        int waitCnt;
        if (timeoutCount > 0) return;
        inValid <= 1'b0;
        waitCnt = 0;
        while (pendingTotal() > 0 && waitCnt < TIMEOUT) begin
            @(posedge clk);
            waitCnt++;
        end
        if (pendingTotal() > 0) begin
            timedOut("results still missing after drain wait");
            return;
        end
        // room for stray results from dropped records
        repeat (20) @(posedge clk);
        assert (gotCount == sentCount) else begin
            $display("ERROR at %0t: %0d results for %0d valid records",
                     $time, gotCount, sentCount);
            errCount++;
        end
    endtask

    task automatic checkResult(input rgbwPkg::fixtureResultT res);
        rgbwPkg::rgbwT exp;
        int fix;
        bit pendingOk;
        fix = int'(res.fixture);
        gotCount++;
        pendingOk = expQ[fix].size() > 0;
        assert (pendingOk) else begin
            $display("fixture %0d gave a result at %0t with no record pending", fix, $time);
            errCount++;
        end
        if (pendingOk) begin
            exp = expQ[fix].pop_front();
            assert (res.level == exp) else begin
                $display("ERROR at %0t: fixture %0d got %h, expected %h",
                         $time, fix, res.level, exp);
                errCount++;
            end
        end
    endtask

    // output side with random back-pressure when stallOut is set
    always @(posedge clk) begin
        if (reset_sig && outValid && outReady) begin
            checkResult(outResult);
        end
        outReady <= stallOut ? ($urandom_range(0, 1) == 1) : 1'b1;
    end

    initial begin
        int waitCnt;
        int pick;
        logic [7:0] wheelIdx [6];
        logic [7:0] mode;
        void'($urandom(32'h13e5c5d9));
        inValid  = 1'b0;
        inByte   = '0;
        outReady = 1'b0;
        wheelIdx = '{8'd0, 8'd35, 8'd36, 8'd100, 8'd200, 8'd250};
        waitCnt = 0;
        do begin
            @(posedge clk);
            waitCnt++;
        end while (!reset_sig && waitCnt < 20);
        if (!reset_sig) timedOut("reset_sig never released");
        assert (!outValid) else begin
            $display("ERROR at %0t: outValid high after reset", $time);
            errCount++;
        end

        // direct mode ignores intensity
        repeat (`NUM_FIXTURES) begin
            putRecord(8'(rgbwPkg::modeDirect), 8'($urandom), 8'($urandom), 8'($urandom),
                      8'($urandom), 8'($urandom), 8'($urandom));
        end

        // wheel positions across all segments
        foreach (wheelIdx[i]) begin
            putRecord(8'(rgbwPkg::modeWheel), 8'h00, wheelIdx[i], 8'h00,
                      8'($urandom), 8'($urandom), 8'($urandom));
        end

        // large white saturates, then every intensity shift
        putRecord(8'(rgbwPkg::modeWheel), 8'h00, 8'd0, 8'd250, 8'h00, 8'h00, 8'h00);
        for (int sh = 0; sh < 8; sh++) begin
            putRecord(8'(rgbwPkg::modeWheel), {3'(sh), 5'($urandom)},
                      8'($urandom_range(0, 120)), 8'($urandom),
                      8'($urandom), 8'($urandom), 8'($urandom));
        end
        waitDrain();

        // unknown modes give no result
        curFix = 0;
        putRecord(8'(rgbwPkg::modeDirect), 8'h10, 8'h00, 8'h11, 8'h22, 8'h33, 8'h44);
        putRecord(8'h00, 8'h20, 8'h05, 8'h01, 8'h02, 8'h03, 8'h04);
        putRecord(8'(rgbwPkg::modeWheel), 8'h40, 8'd77, 8'd30, 8'h00, 8'h00, 8'h00);
        putRecord(8'h5A, 8'hE0, 8'h09, 8'h08, 8'h07, 8'h06, 8'h05);
        waitDrain();

        // several frames under random back-pressure and input gaps
        gapsOn   = 1'b1;
        stallOut = 1'b1;
        repeat (5 * `NUM_FIXTURES) begin
            pick = $urandom_range(0, 3);
            mode = (pick == 0) ? 8'(rgbwPkg::modeDirect) :
                   (pick == 3) ? 8'h3C : 8'(rgbwPkg::modeWheel);
            putRecord(mode, 8'($urandom), 8'($urandom_range(0, 60)), 8'($urandom),
                      8'($urandom), 8'($urandom), 8'($urandom));
        end
        gapsOn   = 1'b0;
        stallOut = 1'b0;
        waitDrain();

        // first flag mid-record restarts at fixture 0
        curFix = 0;
        putRecord(8'(rgbwPkg::modeDirect), 8'h00, 8'h00, 8'h12, 8'h34, 8'h56, 8'h78);
        sendByte(1'b0, 8'(rgbwPkg::modeDirect));
        sendByte(1'b0, 8'hAA);
        sendByte(1'b0, 8'hBB);
        curFix = 0;
        putRecord(8'(rgbwPkg::modeDirect), 8'h00, 8'h00, 8'h9A, 8'hBC, 8'hDE, 8'hF0);
        waitDrain();

        finishRun();
    end

endmodule

/* test/rgbwLamp_assert.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// protocol checks on the lamp top level: stalled
// output and input hold, one-hot dispatch, reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "rgbw_defs.svh"

module rgbwLamp_assert (
    input logic                     clk,
    input logic                     reset_sig,
    input logic                     inValid,
    input rgbwPkg::streamByteT      inByte,
    input logic                     inReady,
    input logic [`NUM_FIXTURES-1:0] cmdValid,
    input logic                     outValid,
    input rgbwPkg::fixtureResultT   outResult,
    input logic                     outReady
);

    int failCount = 0;

    outHeldChk: assert property (@(posedge clk) disable iff (!reset_sig)
        outValid && !outReady |=> outValid && $stable(outResult))
    else begin
        $error("output result changed or dropped while outReady was low");
        failCount++;
    end

    inHeldChk: assert property (@(posedge clk) disable iff (!reset_sig)
        inValid && !inReady |=> inValid && $stable(inByte))
    else begin
        $error("input byte changed or dropped while inReady was low");
        failCount++;
    end

    // at most one command pending
    oneHotChk: assert property (@(posedge clk) disable iff (!reset_sig)
        $onehot0(cmdValid))
    else begin
        $error("more than one cmdValid bit high");
        failCount++;
    end

    resetChk: assert property (@(posedge clk) !reset_sig |=> !outValid)
    else begin
        $error("outValid high in the cycle after reset");
        failCount++;
    end

endmodule

bind rgbwLampTop rgbwLamp_assert protocolChecks (
    .clk       (clk),
    .reset_sig (reset_sig),
    .inValid   (inValid),
    .inByte    (inByte),
    .inReady   (inReady),
    .cmdValid  (cmdValid),
    .outValid  (outValid),
    .outResult (outResult),
    .outReady  (outReady)
);

/* test/clockGen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock, 4 ns period, and a reset held
// low for the first two cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic reset_sig
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // released on the second rising edge
    initial begin
        reset_sig = 1'b0;
        repeat (2) @(posedge clk);
        reset_sig <= 1'b1;
    end

endmodule

/* rtl/rgbwLampTop.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lamp controller top: frame parser, one color
// engine per fixture and the result collector
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "rgbw_defs.svh"

module rgbwLampTop (
    input  logic                   clk,
    input  logic                   reset_sig,
    input  logic                   inValid,
    input  rgbwPkg::streamByteT    inByte,
    output logic                   inReady,
    output logic                   outValid,
    output rgbwPkg::fixtureResultT outResult,
    input  logic                   outReady
);

    logic [`NUM_FIXTURES-1:0] cmdValid;
    logic [`NUM_FIXTURES-1:0] cmdReady;
    rgbwPkg::fixtureCmdT      cmdBus;
    logic [`NUM_FIXTURES-1:0] resValid;
    logic [`NUM_FIXTURES-1:0] resReady;
    rgbwPkg::rgbwT            resBus [`NUM_FIXTURES];

    cmdFrameParser parser (
        .clk       (clk),
        .reset_sig (reset_sig),
        .inValid   (inValid),
        .inByte    (inByte),
        .inReady   (inReady),
        .cmdValid  (cmdValid),
        .cmdOut    (cmdBus),
        .cmdReady  (cmdReady)
    );

    // one engine per fixture, all sharing the command bus
    for (genvar i = 0; i < `NUM_FIXTURES; i++) begin : engines
        hueEngine engine (
            .clk       (clk),
            .reset_sig (reset_sig),
            .cmdValid  (cmdValid[i]),
            .cmd       (cmdBus),
            .cmdReady  (cmdReady[i]),
            .resValid  (resValid[i]),
            .result    (resBus[i]),
            .resReady  (resReady[i])
        );
    end

    resultCollector collector (
        .clk       (clk),
        .reset_sig (reset_sig),
        .resValid  (resValid),
        .resIn     (resBus),
        .resReady  (resReady),
        .outValid  (outValid),
        .outResult (outResult),
        .outReady  (outReady)
    );

endmodule

/* rtl/resultCollector.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// round-robin drain of engine results into one
// registered output stream tagged by fixture
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "rgbw_defs.svh"

module resultCollector (
    input  logic                      clk,
    input  logic                      reset_sig,
    input  logic [`NUM_FIXTURES-1:0]  resValid,
    input  rgbwPkg::rgbwT             resIn [`NUM_FIXTURES],
    output logic [`NUM_FIXTURES-1:0]  resReady,
    output logic                      outValid,
    output rgbwPkg::fixtureResultT    outResult,
    input  logic                      outReady
);

    logic [`FIX_IDX_W-1:0] lastIdx;
    logic [`FIX_IDX_W-1:0] pick;
    logic                  found;
    logic                  canLoad;

    // output register empty or draining
    assign canLoad = !outValid || outReady;

    // first requester after the last one served
    always_comb begin
        logic [`FIX_IDX_W-1:0] cand;
        found = 1'b0;
        pick  = lastIdx;
        for (int k = 1; k <= `NUM_FIXTURES; k++) begin
            cand = `FIX_IDX_W'((lastIdx + k) % `NUM_FIXTURES);
            if (!found && resValid[cand]) begin
                found = 1'b1;
                pick  = cand;
            end
        end
    end

    always_comb begin
        resReady = '0;
        resReady[pick] = found && canLoad;
    end

    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            outValid <= 1'b0;
            lastIdx  <= `FIX_IDX_W'(`NUM_FIXTURES - 1);
        end else if (found && canLoad) begin
            outValid <= 1'b1;
            lastIdx  <= pick;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (found && canLoad) begin
            outResult.fixture <= pick;
            outResult.level   <= resIn[pick];
        end
    end

endmodule

/* rtl/hueEngine.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-fixture color engine: direct pass-through or
// hue wheel walk, white add and intensity scaling
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "rgbw_defs.svh"

module hueEngine (
    input  logic                clk,
    input  logic                reset_sig,
    input  logic                cmdValid,
    input  rgbwPkg::fixtureCmdT cmd,
    output logic                cmdReady,
    output logic                resValid,
    output rgbwPkg::rgbwT       result,
    input  logic                resReady
);

    rgbwPkg::engineStateT state;

    logic [7:0]    red;
    logic [7:0]    green;
    logic [7:0]    blue;
    logic [7:0]    stepCnt;
    logic [2:0]    segIdx;
    logic [5:0]    segPos;
    logic [7:0]    colorIdx;
    logic [7:0]    white;
    logic [2:0]    shiftAmt;
    rgbwPkg::rgbwT resReg;

    function automatic logic [7:0] satAdd(input logic [7:0] a, input logic [7:0] b);
        logic [8:0] sum;
        sum = a + b;
        return sum[8] ? 8'hFF : sum[7:0];
    endfunction

    function automatic logic [7:0] satSub(input logic [7:0] a, input logic [7:0] b);
        return (a < b) ? 8'h00 : a - b;
    endfunction

    assign cmdReady = (state == rgbwPkg::idle);
    assign resValid = (state == rgbwPkg::holdResult);
    assign result   = resReg;

    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            state <= rgbwPkg::idle;
        end else begin
            case (state)
                rgbwPkg::idle: begin
                    if (cmdValid) begin
                        if (cmd.mode == rgbwPkg::modeDirect) begin
                            state <= rgbwPkg::holdResult;
                        end else if (cmd.mode == rgbwPkg::modeWheel) begin
                            state <= rgbwPkg::wheelStep;
                        end
                        // unknown modes are dropped here
                    end
                end
                rgbwPkg::wheelStep: begin
                    if (stepCnt == colorIdx) begin
                        state <= rgbwPkg::whiteAdd;
                    end
                end
                rgbwPkg::whiteAdd:   state <= rgbwPkg::scaleOut;
                rgbwPkg::scaleOut:   state <= rgbwPkg::holdResult;
                rgbwPkg::holdResult: begin
                    if (resReady) begin
                        state <= rgbwPkg::idle;
                    end
                end
                default: state <= rgbwPkg::idle;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        case (state)
            rgbwPkg::idle: begin
                red      <= 8'hFF;
                green    <= 8'h00;
                blue     <= 8'h00;
                stepCnt  <= 8'd0;
                segIdx   <= 3'd0;
                segPos   <= 6'd0;
                colorIdx <= cmd.colorIdx;
                white    <= cmd.level.white;
                shiftAmt <= cmd.intensity[7:5];
                if (cmdValid && cmd.mode == rgbwPkg::modeDirect) begin
                    resReg <= cmd.level;
                end
            end
            rgbwPkg::wheelStep: begin
                case (segIdx)
                    3'd0: blue  <= satAdd(blue, 8'(`WHEEL_STEP));
                    3'd1: red   <= satSub(red, 8'(`WHEEL_STEP));
                    3'd2: green <= satAdd(green, 8'(`WHEEL_STEP));
                    3'd3: blue  <= satSub(blue, 8'(`WHEEL_STEP));
                    3'd4: red   <= satAdd(red, 8'(`WHEEL_STEP));
                    3'd5: green <= satSub(green, 8'(`WHEEL_STEP));
                    default: ;
                endcase
                stepCnt <= stepCnt + 8'd1;
                // segment index tracks stepCnt / SEG_LEN
                if (segIdx < 3'(`NUM_SEGS)) begin
                    if (segPos == 6'(`SEG_LEN - 1)) begin
                        segPos <= 6'd0;
                        segIdx <= segIdx + 3'd1;
                    end else begin
                        segPos <= segPos + 6'd1;
                    end
                end
            end
            rgbwPkg::whiteAdd: begin
                red   <= satAdd(red, white);
                green <= satAdd(green, white);
                blue  <= satAdd(blue, white);
            end
            rgbwPkg::scaleOut: begin
                resReg.red   <= red >> shiftAmt;
                resReg.green <= green >> shiftAmt;
                resReg.blue  <= blue >> shiftAmt;
                resReg.white <= white >> shiftAmt;
            end
            default: ;
        endcase
    end

endmodule

/* rtl/cmdFrameParser.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame parser: builds 7-byte fixture records from
// the byte stream and hands each one to its engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "rgbw_defs.svh"

module cmdFrameParser (
    input  logic                       clk,
    input  logic                       reset_sig,
    input  logic                       inValid,
    input  rgbwPkg::streamByteT        inByte,
    output logic                       inReady,
    output logic [`NUM_FIXTURES-1:0]   cmdValid,
    output rgbwPkg::fixtureCmdT        cmdOut,
    input  logic [`NUM_FIXTURES-1:0]   cmdReady
);

    logic [2:0]            byteCnt;
    logic [`FIX_IDX_W-1:0] fixIdx;
    logic                  pending;
    logic [`FIX_IDX_W-1:0] pendIdx;
    rgbwPkg::fixtureCmdT   cmdReg;

    logic                  accept;
    logic [2:0]            curByte;
    logic [`FIX_IDX_W-1:0] curFix;

    // stall input while a finished record waits
    assign inReady = !pending;
    assign accept  = inValid && inReady;

    // first flag restarts at fixture 0, byte 0
    assign curByte = inByte.first ? 3'd0 : byteCnt;
    assign curFix  = inByte.first ? '0 : fixIdx;

    always_comb begin
        for (int i = 0; i < `NUM_FIXTURES; i++) begin
            cmdValid[i] = pending && (pendIdx == `FIX_IDX_W'(i));
        end
    end

    assign cmdOut = cmdReg;

    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            byteCnt <= '0;
            fixIdx  <= '0;
            pending <= 1'b0;
            pendIdx <= '0;
        end else begin
            if (pending && cmdReady[pendIdx]) begin
                pending <= 1'b0;
            end
            if (accept) begin
                if (curByte == 3'(`RECORD_BYTES - 1)) begin
                    byteCnt <= '0;
                    pending <= 1'b1;
                    pendIdx <= curFix;
                    if (curFix == `FIX_IDX_W'(`NUM_FIXTURES - 1)) begin
                        fixIdx <= '0;
                    end else begin
                        fixIdx <= curFix + 1'b1;
                    end
                end else begin
                    byteCnt <= curByte + 3'd1;
                    fixIdx  <= curFix;
                end
            end
        end
    end

    // record fields in stream order
    always_ff @(posedge clk) begin
        if (accept) begin
            case (curByte)
                3'd0: cmdReg.mode        <= inByte.data;
                3'd1: cmdReg.intensity   <= inByte.data;
                3'd2: cmdReg.colorIdx    <= inByte.data;
                3'd3: cmdReg.level.white <= inByte.data;
                3'd4: cmdReg.level.red   <= inByte.data;
                3'd5: cmdReg.level.green <= inByte.data;
                default: cmdReg.level.blue <= inByte.data;
            endcase
        end
    end

endmodule

/* rtl/rgbwPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types: mode and engine state enums, stream
// byte, color level, command and result structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "rgbw_defs.svh"

package rgbwPkg;

    typedef enum logic [7:0] {
        modeDirect = 8'h21,
        modeWheel  = 8'hA4
    } modeT;

    typedef enum logic [2:0] {
        idle,
        wheelStep,
        whiteAdd,
        scaleOut,
        holdResult
    } engineStateT;

    // first marks the start of a frame
    typedef struct packed {
        logic       first;
        logic [7:0] data;
    } streamByteT;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
        logic [7:0] white;
    } rgbwT;

    typedef struct packed {
        logic [7:0] mode;
        logic [7:0] intensity;
        logic [7:0] colorIdx;
        rgbwT       level;
    } fixtureCmdT;

    typedef struct packed {
        logic [`FIX_IDX_W-1:0] fixture;
        rgbwT                  level;
    } fixtureResultT;

endpackage

/* rtl/rgbw_defs.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lamp controller macros: fixture count, record
// length and hue wheel constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef RGBW_DEFS_SVH
`define RGBW_DEFS_SVH

// engines and fixture number width
`define NUM_FIXTURES 4
`define FIX_IDX_W    2

// mode, intensity, color index, white, red, green, blue
`define RECORD_BYTES 7

// hue wheel ramp
`define WHEEL_STEP   7
`define SEG_LEN      36
`define NUM_SEGS     6

`endif
